/* Bender.yml */
package:
  name: booth_multiplier

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/booth_ctrl_pkg.sv
      - hw/booth_op_pkg.sv
      - hw/operand_capture.sv
      - hw/booth_control.sv
      - hw/booth_datapath.sv
      - hw/result_output.sv
      - hw/booth_multiplier.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/booth_multiplier_props.sv
      - verification/booth_multiplier_tb.sv

/* booth_multiplier.f */
+incdir+hw
hw/booth_ctrl_pkg.sv
hw/booth_op_pkg.sv
hw/operand_capture.sv
hw/booth_control.sv
hw/booth_datapath.sv
hw/result_output.sv
hw/booth_multiplier.sv
verification/booth_multiplier_props.sv
verification/booth_multiplier_tb.sv

/* hw/booth_control.sv */
// booth sequencer, alternates add and shift steps for every multiplier bit and decodes the booth op
`timescale 1ns/100ps
`include "booth_mult_config.svh"
`default_nettype none

module booth_control
  import booth_ctrl_pkg::*;
  import booth_op_pkg::*;
(
  input  wire       doMult,      // system clock
  input  wire       arst_n,      // async reset, active low
  input  wire       load,        // start of a run
  input  wire       prod_lsb,    // accumulator bit 0
  output booth_op_t op,          // valid while add_step
  output logic      add_step,    // high in st_add
  output logic      shift_step,  // high in st_shift
  output logic      finish       // high in st_finish
);

  localparam int unsigned cnt_w = `BOOTH_CNT_W;

  ctrl_state_t      state_q;     // current state
  ctrl_state_t      state_d;     // next state
  logic [cnt_w-1:0] cnt_q;       // completed shifts
  logic [cnt_w-1:0] cnt_inc;     // count after this shift
  logic             prev_lsb_q;  // lsb seen before the last shift

  assign cnt_inc = cnt_q + cnt_w'(1);

  // next state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
      begin
        if (load)
          state_d = st_add;
      end
      st_add:
        state_d = st_shift;  // every add is followed by one shift
      st_shift:
      begin
        if (cnt_inc[cnt_w-1])
          state_d = st_finish;  // top bit set, all bits recoded
        else
          state_d = st_add;
      end
      st_finish:
        state_d = st_idle;
      default:
        state_d = st_idle;
    endcase
  end

  // state, counter and previous lsb memory
  always_ff @(posedge doMult or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q    <= st_idle;
      cnt_q      <= '0;
      prev_lsb_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if ((state_q == st_idle) && load)
      begin
        cnt_q      <= '0;    // fresh run
        prev_lsb_q <= 1'b0;  // implicit bit right of the multiplier lsb
      end
      else if (state_q == st_shift)
      begin
        cnt_q      <= cnt_inc;
        prev_lsb_q <= prod_lsb;  // bit about to be shifted out
      end
    end
  end

  // recoding table on {current, previous}
  always_comb
  begin
    case ({prod_lsb, prev_lsb_q})
      2'b01:   op = op_add;
      2'b10:   op = op_sub;
      default: op = op_none;  // 00 and 11
    endcase
  end

  assign add_step   = (state_q == st_add);
  assign shift_step = (state_q == st_shift);
  assign finish     = (state_q == st_finish);

endmodule : booth_control

`default_nettype wire

/* hw/booth_ctrl_pkg.sv */
// sequencer state type of the booth control, imported by the control and its bound checker
`default_nettype none

package booth_ctrl_pkg;

  // states of the add / shift sequencer
  // one iteration is st_add then st_shift
  typedef enum logic [1:0] {
    st_idle   = 2'd0,  // waiting for load
    st_add    = 2'd1,  // apply the recoded op to the upper half
    st_shift  = 2'd2,  // arithmetic shift, count, remember lsb
    st_finish = 2'd3   // single cycle, raises finish
  } ctrl_state_t;

endpackage : booth_ctrl_pkg

`default_nettype wire

/* hw/booth_datapath.sv */
// booth datapath, product accumulator with add or subtract into the upper half and arithmetic shift
`timescale 1ns/100ps
`include "booth_mult_config.svh"
`default_nettype none

module booth_datapath
  import booth_op_pkg::*;
(
  input  wire                      doMult,      // system clock
  input  wire                      arst_n,      // async reset, active low
  input  wire                      load,        // initialize the accumulator
  input  wire  [`BOOTH_WIDTH-1:0]  mplier,      // multiplier, goes to the lower half
  input  wire  [`BOOTH_WIDTH-1:0]  mcand,       // multiplicand, added to the upper half
  input  booth_op_t                op,          // recoded op for this step
  input  wire                      add_step,    // apply op
  input  wire                      shift_step,  // shift right by one
  output logic                     prod_lsb,    // accumulator bit 0
  output logic [`BOOTH_PROD_W-1:0] acc          // running product
);

  localparam int unsigned w = `BOOTH_WIDTH;

  // one guard bit above the product
  // subtracting the most negative multiplicand would overflow a w-bit upper half
  logic [2*w:0] acc_q;
  logic [w:0]   upper_ext;  // upper half with guard bit
  logic [w:0]   mcand_ext;  // sign extended multiplicand
  logic [w:0]   sum;        // upper half after the op

  assign upper_ext = acc_q[2*w:w];
  assign mcand_ext = {mcand[w-1], mcand};

  always_comb
  begin
    case (op)
      op_add:  sum = upper_ext + mcand_ext;
      op_sub:  sum = upper_ext - mcand_ext;
      default: sum = upper_ext;  // add zero
    endcase
  end

  always_ff @(posedge doMult or negedge arst_n)
  begin
    if (!arst_n)
      acc_q <= '0;
    else if (load)
      acc_q <= {{(w+1){1'b0}}, mplier};  // upper half zero
    else if (add_step)
      acc_q <= {sum, acc_q[w-1:0]};  // lower half untouched
    else if (shift_step)
      acc_q <= {acc_q[2*w], acc_q[2*w:1]};  // sign of the partial sum is kept
  end

  assign prod_lsb = acc_q[0];
  assign acc      = acc_q[2*w-1:0];  // guard bit dropped, product fits in 2w bits

endmodule : booth_datapath

`default_nettype wire

/* hw/booth_mult_config.svh */
// sizing macros for the booth multiplier, included by every rtl and testbench file that needs them
`ifndef BOOTH_MULT_CONFIG_SVH
`define BOOTH_MULT_CONFIG_SVH

// operand width in bits, both operands are two's complement
`define BOOTH_WIDTH 32

// one recoding step per multiplier bit
`define BOOTH_ITERS `BOOTH_WIDTH

// shift counter width
// counts 0 to 32, bit 5 set means the run is complete
`define BOOTH_CNT_W 6

// product width, derived from the operand width
`define BOOTH_PROD_W (2 * `BOOTH_WIDTH)

`endif

/* hw/booth_multiplier.sv */
// top of the sequential booth multiplier, connects input side, control, datapath and output side
`timescale 1ns/100ps
`include "booth_mult_config.svh"
`default_nettype none

module booth_multiplier
  import booth_op_pkg::*;
(
  input  wire                      doMult,        // system clock
  input  wire                      arst_n,        // async reset, active low
  input  wire                      start,         // start strobe, ignored while busy
  input  wire  [`BOOTH_WIDTH-1:0]  multiplicand,  // signed operand a
  input  wire  [`BOOTH_WIDTH-1:0]  multiplier,    // signed operand b
  output logic                     busy,          // run in progress
  output logic                     done,          // product valid pulse
  output logic [`BOOTH_PROD_W-1:0] product        // signed product
);

  logic                     load;        // run start
  logic [`BOOTH_WIDTH-1:0]  mcand;       // held operands
  logic [`BOOTH_WIDTH-1:0]  mplier;
  booth_op_t                op;          // recoded op
  logic                     add_step;
  logic                     shift_step;
  logic                     finish;      // last shift done
  logic                     prod_lsb;
  logic [`BOOTH_PROD_W-1:0] acc;         // running product

  operand_capture u_capture (
    .doMult       (doMult),
    .arst_n       (arst_n),
    .start        (start),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .finish       (finish),
    .busy         (busy),
    .load         (load),
    .mcand        (mcand),
    .mplier       (mplier)
  );

  booth_control u_control (
    .doMult     (doMult),
    .arst_n     (arst_n),
    .load       (load),
    .prod_lsb   (prod_lsb),
    .op         (op),
    .add_step   (add_step),
    .shift_step (shift_step),
    .finish     (finish)
  );

  booth_datapath u_datapath (
    .doMult     (doMult),
    .arst_n     (arst_n),
    .load       (load),
    .mplier     (mplier),
    .mcand      (mcand),
    .op         (op),
    .add_step   (add_step),
    .shift_step (shift_step),
    .prod_lsb   (prod_lsb),
    .acc        (acc)
  );

  result_output u_output (
    .doMult  (doMult),
    .arst_n  (arst_n),
    .finish  (finish),
    .acc     (acc),
    .product (product),
    .done    (done)
  );

endmodule : booth_multiplier

`default_nettype wire

/* hw/booth_op_pkg.sv */
// booth recoding opcode type, shared by the control that decodes it and the datapath that applies it
`default_nettype none

package booth_op_pkg;

  // radix-2 booth recoding of the pair {current lsb, previous lsb}
  // 00 and 11 add nothing, 01 adds, 10 subtracts
  typedef enum logic [1:0] {
    op_none = 2'd0,  // pair 00 or 11
    op_add  = 2'd1,  // pair 01, end of a run of ones
    op_sub  = 2'd2   // pair 10, start of a run of ones
  } booth_op_t;

endpackage : booth_op_pkg

`default_nettype wire

/* hw/operand_capture.sv */
// input side of the booth multiplier, accepts a start while idle and holds the operands for the run
`timescale 1ns/100ps
`include "booth_mult_config.svh"
`default_nettype none

module operand_capture
(
  input  wire                     doMult,        // system clock
  input  wire                     arst_n,        // async reset, active low
  input  wire                     start,         // request strobe
  input  wire [`BOOTH_WIDTH-1:0]  multiplicand,  // operand a, sampled on accept
  input  wire [`BOOTH_WIDTH-1:0]  multiplier,    // operand b, sampled on accept
  input  wire                     finish,        // end of run from the control
  output logic                    busy,          // a product is in flight
  output logic                    load,          // one cycle after the accepting edge
  output logic [`BOOTH_WIDTH-1:0] mcand,         // held multiplicand
  output logic [`BOOTH_WIDTH-1:0] mplier         // held multiplier
);

  logic accept;  // start seen while idle

  // starts during a run are dropped here and nowhere else
  assign accept = start & ~busy;

  // control flags
  always_ff @(posedge doMult or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy <= 1'b0;
      load <= 1'b0;
    end
    else
    begin
      load <= accept;  // pulse, accept can only be high for one edge
      if (accept)
        busy <= 1'b1;
      else if (finish)
        busy <= 1'b0;  // drops on the edge that registers the product
    end
  end

  // operand holding registers, only written on accept
  always_ff @(posedge doMult)
  begin
    if (accept)
    begin
      mcand  <= multiplicand;
      mplier <= multiplier;  // stays stable while busy
    end
  end

endmodule : operand_capture

`default_nettype wire

/* hw/result_output.sv */
// output side of the booth multiplier, holds the last product and pulses done with it
`timescale 1ns/100ps
`include "booth_mult_config.svh"
`default_nettype none

module result_output
(
  input  wire                      doMult,   // system clock
  input  wire                      arst_n,   // async reset, active low
  input  wire                      finish,   // run complete, acc is final
  input  wire  [`BOOTH_PROD_W-1:0] acc,      // accumulator from the datapath
  output logic [`BOOTH_PROD_W-1:0] product,  // last finished product
  output logic                     done      // one cycle, aligned with product
);

  // product register
  // kept until the next finish overwrites it
  always_ff @(posedge doMult or negedge arst_n)
  begin
    if (!arst_n)
      product <= '0;
    else if (finish)
      product <= acc;
  end

  // done is finish delayed by one edge
  always_ff @(posedge doMult or negedge arst_n)
  begin
    if (!arst_n)
      done <= 1'b0;
    else
      done <= finish;  // finish lasts one cycle so done does too
  end

endmodule : result_output

`default_nettype wire

/* verification/booth_multiplier_props.sv */
// assertions bound into the booth control, check handshake timing and the shift counter
`timescale 1ns/100ps
`include "booth_mult_config.svh"
`default_nettype none

module booth_multiplier_props
  import booth_ctrl_pkg::*;
(
  input wire                    doMult,      // system clock
  input wire                    arst_n,      // async reset, active low
  input wire                    load,
  input wire                    add_step,
  input wire                    shift_step,
  input wire                    finish,
  input ctrl_state_t            state,       // sequencer state
  input wire [`BOOTH_CNT_W-1:0] cnt,         // completed shifts
  input wire                    busy,        // from the input side
  input wire                    done         // from the output side
);

  // a run only starts after the input side has accepted it
  a_load_busy: assert property (@(posedge doMult) disable iff (!arst_n) load |-> busy)
    else $error("load seen while busy is low");

  a_done_follows: assert property (@(posedge doMult) disable iff (!arst_n) finish |=> done)
    else $error("done missing one edge after finish");

  a_cnt_range: assert property (@(posedge doMult) disable iff (!arst_n)
                                cnt <= `BOOTH_ITERS)
    else $error("shift counter past the iteration count");

  // add and shift are separate states
  a_no_overlap: assert property (@(posedge doMult) disable iff (!arst_n)
                                 !(add_step && shift_step))
    else $error("add_step and shift_step high together");

  // the run ends only once every multiplier bit has been shifted out
  a_finish_count: assert property (@(posedge doMult) disable iff (!arst_n)
                                   (state == st_finish) |-> (cnt == `BOOTH_ITERS))
    else $error("finish state reached before all shifts were counted");

endmodule : booth_multiplier_props

`default_nettype wire

/* verification/booth_multiplier_tb.sv */
// testbench for the booth multiplier, runs directed and random products against a reference model
`timescale 1ns/100ps
`include "booth_mult_config.svh"
`default_nettype none

module booth_multiplier_tb
  import booth_op_pkg::*;
;

  localparam int n_directed = 12;
  localparam int n_random   = 200;
  localparam int n_tests    = n_directed + n_random + 1;  // one extra run with a dropped start
  localparam int latency    = 66;                         // start edge to done edge
  localparam int limit      = 80 * (n_tests + 2);         // cycle budget for the whole run

  logic                     doMult;
  logic                     arst_n;
  logic                     start;
  logic [`BOOTH_WIDTH-1:0]  multiplicand;
  logic [`BOOTH_WIDTH-1:0]  multiplier;
  logic                     busy;
  logic                     done;
  logic [`BOOTH_PROD_W-1:0] product;

  int                       cyc;           // rising edges since time 0
  int                       start_edge;    // edge that sampled the accepted start
  bit                       in_flight;     // a product is expected
  int                       n_done;        // products checked so far
  logic [`BOOTH_PROD_W-1:0] exp_product;
  logic [`BOOTH_PROD_W-1:0] last_product;  // what product must hold between runs
  booth_op_t                exp_op;        // first recoded op of the run
  int unsigned              seed_val;

  // directed operand pairs, zero, one, sign corners, alternating bits, mixed signs
  logic [`BOOTH_WIDTH-1:0] dir_a [n_directed] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000,
    32'h80000000, 32'h55555555, 32'haaaaaaaa, 32'hfffe1dc0, 32'h7, 32'h7fffffff, 32'h7fffffff,
    32'h1};
  logic [`BOOTH_WIDTH-1:0] dir_b [n_directed] = '{32'h00bc614e, 32'h1, 32'hffffffff,
    32'hffffffff, 32'h80000000, 32'haaaaaaaa, 32'h55555555, 32'h315, 32'hfffe7961,
    32'h80000000, 32'h7fffffff, 32'hfffffff9};

  booth_multiplier dut0 (
    .doMult       (doMult),
    .arst_n       (arst_n),
    .start        (start),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .busy         (busy),
    .done         (done),
    .product      (product)
  );

  bind booth_control booth_multiplier_props u_props (
    .doMult     (doMult),
    .arst_n     (arst_n),
    .load       (load),
    .add_step   (add_step),
    .shift_step (shift_step),
    .finish     (finish),
    .state      (state_q),
    .cnt        (cnt_q),
    .busy       (booth_multiplier_tb.dut0.busy),
    .done       (booth_multiplier_tb.dut0.done)
  );

  always #20 doMult = ~doMult;  // 40 ns period

  always @(posedge doMult)
    cyc <= cyc + 1;

  // signed product straight from the operand values, wide enough that nothing overflows
  function automatic logic signed [`BOOTH_PROD_W-1:0] ref_product(
    input logic signed [`BOOTH_WIDTH-1:0] a,
    input logic signed [`BOOTH_WIDTH-1:0] b);
    logic signed [`BOOTH_PROD_W-1:0] ea;
    logic signed [`BOOTH_PROD_W-1:0] eb;
    ea = a;  // sign extended by the assignment
    eb = b;
    return ea * eb;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic compare_product(input string name, input logic [`BOOTH_PROD_W-1:0] got,
                                 input logic [`BOOTH_PROD_W-1:0] exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, name, got, exp));
  endtask

  task automatic compare_latency(input int got, input int exp);
    if (got != exp)
      stop_with_error($sformatf("CHECK FAILED at %0t: done latency got %0d expected %0d",
                                $time, got, exp));
  endtask

  task automatic compare_op(input booth_op_t got, input booth_op_t exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED at %0t: dut0.u_control.op got %s expected %s",
                                $time, got.name(), exp.name()));
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                $time, name, got, exp));
  endtask

  // one product, optionally with a second start thrown in while busy
  task automatic run_mult(input logic [`BOOTH_WIDTH-1:0] a, input logic [`BOOTH_WIDTH-1:0] b,
                          input bit intrude);
    @(posedge doMult);
    start        <= 1'b1;
    multiplicand <= a;
    multiplier   <= b;
    @(posedge doMult);  // this edge samples start
    start       <= 1'b0;
    start_edge  = cyc + 1;  // cyc still holds the previous edge here
    exp_product = ref_product(a, b);
    exp_op      = b[0] ? op_sub : op_none;  // previous lsb starts at zero
    in_flight   = 1'b1;
    if (intrude)
    begin
      repeat (10) @(posedge doMult);
      start        <= 1'b1;
      multiplicand <= ~a;  // must not reach the result
      multiplier   <= ~b;
      @(posedge doMult);
      start <= 1'b0;
    end
    while (in_flight)
      @(posedge doMult);
  endtask

  // compare process, samples on the falling edge where outputs are settled
  always @(negedge doMult)
  begin : compare_proc
    int age;
    if (arst_n && in_flight)
    begin
      age = cyc - start_edge;
      if (age == 1)
      begin
        compare_flag("dut0.u_control.add_step", dut0.u_control.add_step, 1'b1);
        compare_op(dut0.u_control.op, exp_op);
      end
      if (done)
      begin
        compare_latency(age, latency);
        compare_flag("busy", busy, 1'b0);  // cleared on the done edge
        compare_product("product", product, exp_product);
        last_product = product;
        in_flight    = 1'b0;
        n_done++;
      end
      else if (age >= latency)
        compare_flag("done", done, 1'b1);  // done is late
      else
      begin
        compare_flag("busy", busy, 1'b1);
        compare_product("product", product, last_product);  // old result held
      end
    end
    else if (arst_n)
    begin
      compare_flag("done", done, 1'b0);
      compare_product("product", product, last_product);
    end
  end

  // watchdog
  always @(posedge doMult)
  begin
    if (cyc >= limit)
      stop_with_error($sformatf("timeout, run not complete after %0d cycles", limit));
  end

  initial
  begin
    doMult       = 1'b0;
    arst_n       = 1'b0;
    start        = 1'b0;
    multiplicand = '0;
    multiplier   = '0;
    cyc          = 0;
    start_edge   = 0;
    in_flight    = 1'b0;
    n_done       = 0;
    exp_product  = '0;
    last_product = '0;
    exp_op       = op_none;
    seed_val     = $urandom(87);
    repeat (2) @(posedge doMult);
    arst_n <= 1'b1;
    @(negedge doMult);
    compare_flag("done", done, 1'b0);  // reset values before any start
    compare_flag("busy", busy, 1'b0);
    compare_product("product", product, '0);
    for (int i = 0; i < n_directed; i++)
      run_mult(dir_a[i], dir_b[i], 1'b0);
    run_mult(32'hfedcba98, 32'h01234567, 1'b1);  // second start must be dropped
    for (int i = 0; i < n_random; i++)
      run_mult($urandom(), $urandom(), 1'b0);
    repeat (4) @(posedge doMult);
    if (n_done == n_tests)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
      stop_with_error($sformatf("only %0d of %0d products checked", n_done, n_tests));
  end

endmodule : booth_multiplier_tb

`default_nettype wire
